// ==== fetch_top.f ====
common/fetch_pkg.sv
rtl/pc_gen.sv
mem/line_buffer.sv
mem/burst_adapter.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
tb/fetch_mem_model.sv
tb/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_top

sources:
  - common/fetch_pkg.sv
  - rtl/pc_gen.sv
  - mem/line_buffer.sv
  - mem/burst_adapter.sv
  - rtl/fetch_queue.sv
  - rtl/fetch_top.sv
  - target: simulation
    files:
      - tb/fetch_mem_model.sv
      - tb/fetch_tb.sv

// ==== tb/fetch_tb.sv ====
module fetch_tb
    import fetch_pkg::*;
();

    logic  clk;
    logic  rst;
    addr_t bmem_addr;
    logic  bmem_read;
    logic  bmem_ready;
    beat_t bmem_rdata;
    logic  bmem_rvalid;
    logic  redirect;
    addr_t redirect_pc;
    inst_t inst;
    addr_t pc;
    logic  inst_valid;
    logic  inst_ready;
    logic  stall_mode;

    int    check_count;
    int    error_count;
    int    timeout_count;
    addr_t got_pc[$];
    inst_t got_inst[$];
    addr_t read_addr[$];   // bmem reads since the last reset

    fetch_top dut (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .inst_o        (inst),
        .pc_o          (pc),
        .inst_valid_o  (inst_valid),
        .inst_ready_i  (inst_ready)
    );

    fetch_mem_model mem_model (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall_mode),
        .bmem_read_i   (bmem_read),
        .bmem_addr_i   (bmem_addr),
        .bmem_ready_o  (bmem_ready),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic inst_t expected_inst(input addr_t a);
        return a ^ 32'h5a5a0000;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // sampled mid cycle, a pulse is high for exactly one cycle
    always @(negedge clk) begin
        if (!rst && bmem_read) begin
            read_addr.push_back(bmem_addr);
            check_equal(bmem_ready, 1'b1, "read pulse while memory not ready");
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        read_addr.delete();
    endtask

    // a head seen with ready high leaves the queue at the next edge
    task automatic collect_insts(input int n, input int limit);
        int cycles;
        got_pc.delete();
        got_inst.delete();
        cycles = 0;
        while (got_pc.size() < n && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (inst_valid && inst_ready && !redirect) begin   // flush wins over dequeue
                got_pc.push_back(pc);
                got_inst.push_back(inst);
            end
        end
        if (got_pc.size() < n) begin
            timeout_count++;
            $display("timeout at %0t, only %0d of %0d instructions arrived",
                     $time, got_pc.size(), n);
        end
    endtask

    // returns once a line fill has started on the memory bus
    task automatic wait_line_fill(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!bmem_read && cycles < limit);
        if (!bmem_read) begin
            timeout_count++;
            $display("timeout at %0t, no memory read within %0d cycles", $time, limit);
        end
    endtask

    task automatic check_stream(input addr_t start, input string what);
        addr_t a;
        for (int k = 0; k < got_pc.size(); k++) begin
            a = start + 4 * k;
            check_equal(got_pc[k], a, {what, " pc"});
            check_equal(got_inst[k], expected_inst(a), {what, " instruction"});
        end
    endtask

    // lines covered by n sequential words from start
    function automatic int lines_touched(input addr_t start, input int n);
        return (start + 4 * (n - 1)) / LINE_BYTES - start / LINE_BYTES + 1;
    endfunction

    task automatic sequential_fetch();
        @(posedge clk);
        inst_ready <= 1'b1;
        apply_reset();
        collect_insts(8, 200);
        check_stream(RESET_PC, "sequential");
    endtask

    task automatic line_crossing();
        apply_reset();
        collect_insts(20, 400);
        check_stream(RESET_PC, "line crossing");
        check_equal(read_addr.size(), lines_touched(RESET_PC, 20),
                    "line fills for 20 instructions");
        foreach (read_addr[i]) begin
            check_equal(read_addr[i] % LINE_BYTES, 0, "read address alignment");
        end
    endtask

    task automatic back_pressure();
        int fill_lines;
        fill_lines = lines_touched(RESET_PC, FQ_DEPTH);
        @(posedge clk);
        inst_ready <= 1'b0;
        apply_reset();
        repeat (60) @(posedge clk);
        @(negedge clk);
        check_equal(inst_valid, 1'b1, "queue holds instructions under back-pressure");
        check_equal(read_addr.size(), fill_lines, "line fills while stalled");
        @(posedge clk);
        inst_ready <= 1'b1;
        collect_insts(16, 400);
        check_stream(RESET_PC, "drain");
    endtask

    task automatic redirect_flow();
        addr_t target;
        target = 32'h1ecf0a14;
        apply_reset();
        collect_insts(5, 200);
        check_stream(RESET_PC, "before redirect");
        wait_line_fill(100);   // old path has a miss outstanding now
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= target;
        @(posedge clk);
        redirect    <= 1'b0;
        collect_insts(10, 400);
        check_stream(target, "after redirect");
    endtask

    task automatic memory_stall();
        @(posedge clk);
        stall_mode <= 1'b1;
        apply_reset();
        collect_insts(24, 3000);
        check_stream(RESET_PC, "memory stall");
        @(posedge clk);
        stall_mode <= 1'b0;
    endtask

    initial begin
        rst           = 1'b1;
        inst_ready    = 1'b0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        stall_mode    = 1'b0;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;

        sequential_fetch();
        line_crossing();
        back_pressure();
        redirect_flow();
        memory_stall();

        $display("%0d checks, %0d errors, %0d timeouts", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : fetch_tb

// ==== tb/fetch_mem_model.sv ====
module fetch_mem_model
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  stall_i,        // random ready and gaps between beats

    input  logic  bmem_read_i,
    input  addr_t bmem_addr_i,
    output logic  bmem_ready_o,
    output beat_t bmem_rdata_o,
    output logic  bmem_rvalid_o
);

    addr_t       base_q;    // line address of the burst in progress
    logic [1:0]  beat_q;
    logic        busy_q;
    logic [31:0] lcg_q;
    addr_t       beat_addr;

    assign beat_addr = base_q + {beat_q, 3'b000};

    // numerical recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory content, the word at byte address a
    function automatic inst_t data_word(input addr_t a);
        return a ^ 32'h5a5a0000;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            lcg_q         <= 32'h3521;
            busy_q        <= 1'b0;
            beat_q        <= '0;
            bmem_ready_o  <= 1'b1;
            bmem_rvalid_o <= 1'b0;
            bmem_rdata_o  <= '0;
        end else begin
            lcg_q         <= lcg_next(lcg_q);
            bmem_ready_o  <= stall_i ? (lcg_q[17:16] != 2'b00) : 1'b1;   // about 3 in 4
            bmem_rvalid_o <= 1'b0;
            if (bmem_read_i) begin
                busy_q <= 1'b1;
                base_q <= bmem_addr_i;
                beat_q <= '0;
            end else if (busy_q && (!stall_i || lcg_q[21])) begin
                bmem_rvalid_o <= 1'b1;
                bmem_rdata_o  <= {data_word(beat_addr + 32'd4), data_word(beat_addr)};
                beat_q        <= beat_q + 1'b1;
                if (beat_q == 2'd3) begin
                    busy_q <= 1'b0;   // last beat of the line
                end
            end
        end
    end

endmodule : fetch_mem_model

// ==== rtl/fetch_top.sv ====
module fetch_top
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // burst memory, read side only
    output addr_t bmem_addr_o,
    output logic  bmem_read_o,
    input  logic  bmem_ready_i,
    input  beat_t bmem_rdata_i,
    input  logic  bmem_rvalid_i,

    // redirect from the back end
    input  logic  redirect_i,
    input  addr_t redirect_pc_i,

    // instruction stream to the consumer
    output inst_t inst_o,
    output addr_t pc_o,
    output logic  inst_valid_o,
    input  logic  inst_ready_i
);

    logic  fetch_req;
    addr_t fetch_addr;
    logic  fetch_resp;
    inst_t fetch_word;
    logic  enq;          // response kept, goes into the queue
    logic  q_full;
    logic  q_empty;

    logic  line_req;
    addr_t line_addr;
    logic  line_valid;
    line_t line_data;

    assign inst_valid_o = !q_empty;

    pc_gen pc_gen_i (
        .clk           (clk),
        .rst           (rst),
        .q_full_i      (q_full),
        .bmem_ready_i  (bmem_ready_i),
        .fetch_resp_i  (fetch_resp),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .fetch_req_o   (fetch_req),
        .fetch_addr_o  (fetch_addr),
        .enq_o         (enq)
    );

    line_buffer line_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_req_i  (fetch_req),
        .fetch_addr_i (fetch_addr),
        .fetch_resp_o (fetch_resp),
        .fetch_word_o (fetch_word),
        .line_req_o   (line_req),
        .line_addr_o  (line_addr),
        .line_valid_i (line_valid),
        .line_data_i  (line_data)
    );

    burst_adapter burst_adapter_i (
        .clk           (clk),
        .rst           (rst),
        .line_req_i    (line_req),
        .line_addr_i   (line_addr),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .line_valid_o  (line_valid),
        .line_data_o   (line_data)
    );

    // pc of a kept response is still the request address
    fetch_queue #(.DEPTH(FQ_DEPTH)) fetch_queue_i (
        .clk     (clk),
        .rst     (rst),
        .flush_i (redirect_i),
        .enq_i   (enq),
        .inst_i  (fetch_word),
        .pc_i    (fetch_addr),
        .deq_i   (inst_ready_i),
        .inst_o  (inst_o),
        .pc_o    (pc_o),
        .empty_o (q_empty),
        .full_o  (q_full)
    );

endmodule : fetch_top

// ==== rtl/fetch_queue.sv ====
module fetch_queue
    import fetch_pkg::*;
#(
    parameter int DEPTH = FQ_DEPTH   // power of two, 2 or more
) (
    input  logic  clk,
    input  logic  rst,

    input  logic  flush_i,
    input  logic  enq_i,
    input  inst_t inst_i,
    input  addr_t pc_i,
    input  logic  deq_i,

    output inst_t inst_o,
    output addr_t pc_o,
    output logic  empty_o,
    output logic  full_o
);

    localparam int PTR_W = $clog2(DEPTH);

    inst_t inst_mem [DEPTH];
    addr_t pc_mem   [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;   // one extra bit to tell full from empty
    logic             do_enq;
    logic             do_deq;

    assign full_o  = (count_q == (PTR_W + 1)'(DEPTH));
    assign empty_o = (count_q == '0);

    assign do_enq = enq_i && !full_o;
    assign do_deq = deq_i && !empty_o;   // consumer strobe ignored when empty

    assign inst_o = inst_mem[rd_ptr_q];
    assign pc_o   = pc_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at DEPTH
            end
            if (do_deq) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end

            case ({do_enq, do_deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_enq) begin
            inst_mem[wr_ptr_q] <= inst_i;
            pc_mem[wr_ptr_q]   <= pc_i;
        end
    end

    // pc_gen must hold requests back while the queue is full
    assert property (@(posedge clk) disable iff (rst)
        enq_i |-> !full_o)
        else $error("fetch_queue: enqueue while full, instruction lost");

endmodule : fetch_queue

// ==== mem/burst_adapter.sv ====
module burst_adapter
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  line_req_i,
    input  addr_t line_addr_i,

    input  logic  bmem_ready_i,
    input  beat_t bmem_rdata_i,
    input  logic  bmem_rvalid_i,
    output addr_t bmem_addr_o,
    output logic  bmem_read_o,

    output logic  line_valid_o,
    output line_t line_data_o
);

    localparam int CNT_W = $clog2(BEATS_PER_LINE);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(BEATS_PER_LINE - 1);

    typedef enum logic [1:0] {
        BA_IDLE,
        BA_ISSUE,
        BA_COLLECT
    } ba_state_e;

    ba_state_e        state_q;
    addr_t            addr_q;
    line_t            line_q;
    logic [CNT_W-1:0] beat_cnt_q;
    logic             line_valid_q;
    logic             last_beat;

    assign bmem_read_o  = (state_q == BA_ISSUE) && bmem_ready_i;   // single cycle
    assign bmem_addr_o  = addr_q;
    assign line_valid_o = line_valid_q;
    assign line_data_o  = line_q;

    assign last_beat = bmem_rvalid_i && (beat_cnt_q == LAST_BEAT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= BA_IDLE;
            beat_cnt_q   <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= 1'b0;
            case (state_q)
                BA_IDLE: begin
                    if (line_req_i) begin
                        state_q <= BA_ISSUE;
                    end
                end
                BA_ISSUE: begin
                    if (bmem_ready_i) begin
                        state_q    <= BA_COLLECT;
                        beat_cnt_q <= '0;
                    end
                end
                BA_COLLECT: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                    end
                    if (last_beat) begin
                        state_q      <= BA_IDLE;
                        line_valid_q <= 1'b1;
                    end
                end
                default: state_q <= BA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == BA_IDLE && line_req_i) begin
            addr_q <= line_addr_i;
        end
        // lowest beat enters first and ends up at the bottom
        if (state_q == BA_COLLECT && bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[$bits(line_t)-1:$bits(beat_t)]};
        end
    end

    // line buffer waits for each line before asking for the next
    assert property (@(posedge clk) disable iff (rst)
        line_req_i |-> state_q == BA_IDLE)
        else $error("burst_adapter: line request while a burst is in progress");

endmodule : burst_adapter

// ==== mem/line_buffer.sv ====
module line_buffer
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // fetch side
    input  logic  fetch_req_i,
    input  addr_t fetch_addr_i,
    output logic  fetch_resp_o,
    output inst_t fetch_word_o,

    // refill side
    output logic  line_req_o,
    output addr_t line_addr_o,
    input  logic  line_valid_i,
    input  line_t line_data_i
);

    localparam int OFS_W  = $clog2(LINE_BYTES);       // byte offset in a line
    localparam int IDX_W  = $clog2(WORDS_PER_LINE);   // word select
    localparam int WORD_W = $bits(inst_t);

    typedef enum logic [1:0] {
        LB_IDLE,
        LB_LOOKUP,
        LB_FILL
    } lb_state_e;

    lb_state_e        state_q;
    addr_t            addr_q;   // address being served
    line_t            line_q;
    logic [31:OFS_W]  tag_q;
    logic             valid_q;
    logic             hit;
    logic [IDX_W-1:0] word_idx;

    assign hit      = valid_q && (tag_q == addr_q[31:OFS_W]);
    assign word_idx = addr_q[OFS_W-1:2];

    // answer straight from the lookup state
    assign fetch_resp_o = (state_q == LB_LOOKUP) && hit;
    assign fetch_word_o = line_q[word_idx*WORD_W +: WORD_W];

    assign line_req_o  = (state_q == LB_LOOKUP) && !hit;
    assign line_addr_o = {addr_q[31:OFS_W], {OFS_W{1'b0}}};   // line aligned

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= LB_IDLE;
            valid_q <= 1'b0;
        end else begin
            case (state_q)
                LB_IDLE: begin
                    if (fetch_req_i) begin
                        state_q <= LB_LOOKUP;
                    end
                end
                LB_LOOKUP: begin
                    state_q <= hit ? LB_IDLE : LB_FILL;
                end
                LB_FILL: begin
                    // back to lookup, which hits now
                    if (line_valid_i) begin
                        state_q <= LB_LOOKUP;
                        valid_q <= 1'b1;
                    end
                end
                default: state_q <= LB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LB_IDLE && fetch_req_i) begin
            addr_q <= fetch_addr_i;
        end
        if (state_q == LB_FILL && line_valid_i) begin
            line_q <= line_data_i;
            tag_q  <= addr_q[31:OFS_W];
        end
    end

endmodule : line_buffer

// ==== rtl/pc_gen.sv ====
module pc_gen
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  q_full_i,
    input  logic  bmem_ready_i,
    input  logic  fetch_resp_i,
    input  logic  redirect_i,
    input  addr_t redirect_pc_i,

    output logic  fetch_req_o,
    output addr_t fetch_addr_o,
    output logic  enq_o
);

    addr_t pc_q;
    logic  pending_q;   // request in flight to the line buffer
    logic  discard_q;   // in-flight response belongs to the old path

    // one request at a time, never into a full queue
    assign fetch_req_o  = !pending_q && !q_full_i && bmem_ready_i && !redirect_i;
    assign fetch_addr_o = pc_q;

    // a response racing a redirect is stale as well
    assign enq_o = fetch_resp_i && !discard_q && !redirect_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q      <= RESET_PC;
            pending_q <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (enq_o) begin
                pc_q <= pc_q + 32'd4;
            end

            if (fetch_req_o) begin
                pending_q <= 1'b1;
            end else if (fetch_resp_i) begin
                pending_q <= 1'b0;
            end

            // stale response still has to come back before the next request
            if (fetch_resp_i) begin
                discard_q <= 1'b0;
            end else if (redirect_i && pending_q) begin
                discard_q <= 1'b1;
            end
        end
    end

    // redirect targets come from outside, misaligned ones would split a word
    assert property (@(posedge clk) disable iff (rst)
        fetch_req_o |-> fetch_addr_o[1:0] == 2'b00)
        else $error("pc_gen: fetch address %h not word aligned", fetch_addr_o);

endmodule : pc_gen

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    // line geometry
    localparam int LINE_BYTES     = 32;
    localparam int BEATS_PER_LINE = 4;   // 64-bit beats per line
    localparam int WORDS_PER_LINE = 8;   // 32-bit instructions per line

    // default depth of the instruction queue
    localparam int FQ_DEPTH = 8;

    // byte address
    typedef logic [31:0] addr_t;

    // one RV32I instruction word
    typedef logic [31:0] inst_t;

    // one beat on the memory read bus
    typedef logic [63:0] beat_t;

    // a whole line as held by the line buffer
    typedef logic [LINE_BYTES*8-1:0] line_t;

    // first fetch after reset
    localparam addr_t RESET_PC = 32'h1eceb000;

endpackage : fetch_pkg
